/* src/audio_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host bus types and the peripheral address map
// The region offsets are added to AE_BASE and compared with addr[31:16]
// Only the low 16 address bits select a word inside a region
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package audio_bus_pkg;

    // Host request, held steady until ready is seen
    typedef struct packed {
        logic        valid;
        logic [3:0]  wstrb;
        logic [31:0] addr;
        logic [31:0] wdata;
    } iomem_req_t;

    // Peripheral response, ready high for one cycle per request
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } iomem_rsp_t;

    localparam logic [15:0] AE_BASE = 16'h6000;

    localparam logic [15:0] REGION_COEF   = 16'h0000;
    localparam logic [15:0] REGION_RESULT = 16'h0100;
    localparam logic [15:0] REGION_STATUS = 16'h0200;
    localparam logic [15:0] REGION_START  = 16'h0300;
    localparam logic [15:0] REGION_INPUT  = 16'h0400;

endpackage

/* src/audio_dsp_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Engine sizes, program word layout and pipeline records
// Coefficients are signed Q1.15, samples signed 16 bit
// The accumulator is 40 bits and is not checked for overflow
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package audio_dsp_pkg;

    localparam int CHANNELS = 16;
    localparam int FRAMES   = 32;
    localparam int CODE     = 256;
    localparam int SLOTS    = 16;
    localparam int AUDIO    = CHANNELS * FRAMES;

    localparam int CHAN_W   = $clog2(CHANNELS);
    localparam int FRAME_W  = $clog2(FRAMES);
    localparam int CODE_W   = $clog2(CODE);
    localparam int SLOT_W   = $clog2(SLOTS);
    localparam int AUDIO_W  = $clog2(AUDIO);

    localparam int SAMPLE_W = 16;
    // Fraction bits of the coefficient
    localparam int Q_FRAC   = 15;

    typedef enum logic [1:0] {
        OP_MAC  = 2'd0,
        OP_SAVE = 2'd1,
        OP_HALT = 2'd2,
        OP_BAD  = 2'd3
    } op_t;

    typedef struct packed {
        op_t                        op;
        logic [CHAN_W-1:0]          chan;
        logic [FRAME_W-1:0]         delay;
        logic [4:0]                 spare;
        logic signed [SAMPLE_W-1:0] coef;
    } mac_word_t;

    typedef struct packed {
        op_t               op;
        logic [SLOT_W-1:0] slot;
        logic [25:0]       spare;
    } save_word_t;

    // Same program word seen as a MAC or as a save
    typedef union packed {
        mac_word_t  mac;
        save_word_t save;
    } prog_word_u;

    typedef logic signed [39:0] acc_t;

    typedef struct packed {
        logic                       valid;
        op_t                        kind;
        logic signed [SAMPLE_W-1:0] coef;
        logic [SLOT_W-1:0]          slot;
    } exec_cmd_t;

    typedef struct packed {
        logic              valid;
        op_t               kind;
        logic [SLOT_W-1:0] slot;
        acc_t              acc;
    } result_cmd_t;

endpackage

/* src/dpram.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-port RAM with one write port and one registered read port
// A read of the word being written returns the old contents
// Contents are undefined after power up
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module dpram #(
    parameter int BITS = 16,
    parameter int SIZE = 256
) (
    input  logic                    ck,
    input  logic                    we,
    input  logic [$clog2(SIZE)-1:0] waddr,
    input  logic [BITS-1:0]         wdata,
    input  logic                    re,
    input  logic [$clog2(SIZE)-1:0] raddr,
    output logic [BITS-1:0]         rdata
);

    logic [BITS-1:0] mem [SIZE];

    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* src/bus_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host bus slave for the audio engine
// Ready comes one cycle after valid, two for result reads
// Addresses outside the five regions are never answered
// Input writes are dropped while the allow bit is clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module bus_port (
    input  logic                                ck,
    input  logic                                rst,
    input  audio_bus_pkg::iomem_req_t           iomem_req,
    output audio_bus_pkg::iomem_rsp_t           iomem_rsp,
    output logic                                coef_we,
    output logic                                audio_we,
    output logic [audio_dsp_pkg::SLOT_W-1:0]    result_raddr,
    input  logic [audio_dsp_pkg::SAMPLE_W-1:0]  result_rdata,
    input  logic                                done,
    input  logic                                error,
    output logic [audio_dsp_pkg::FRAME_W-1:0]   frame,
    output logic                                start
);
    import audio_bus_pkg::*;
    import audio_dsp_pkg::*;

    logic [15:0]      page;
    logic             hit_coef, hit_result, hit_status, hit_start, hit_input;
    logic             accept, write;
    logic             busy, result_pend;
    logic             ready_q;
    logic [31:0]      rdata_q;
    logic [FRAME_W:0] ctrl;
    logic             allow;

    assign page       = iomem_req.addr[31:16];
    assign hit_coef   = page == AE_BASE + REGION_COEF;
    assign hit_result = page == AE_BASE + REGION_RESULT;
    assign hit_status = page == AE_BASE + REGION_STATUS;
    assign hit_start  = page == AE_BASE + REGION_START;
    assign hit_input  = page == AE_BASE + REGION_INPUT;

    // One accept per request, busy holds off until ready has been shown
    assign accept = iomem_req.valid && !busy &&
                    (hit_coef || hit_result || hit_status || hit_start || hit_input);
    assign write  = |iomem_req.wstrb;

    assign allow = ctrl[0];
    assign frame = ctrl[FRAME_W:1];

    assign coef_we      = accept && hit_coef && write;
    assign audio_we     = accept && hit_input && write && allow;
    assign result_raddr = iomem_req.addr[2 +: SLOT_W];

    always_ff @(posedge ck) begin
        if (rst) begin
            busy        <= 1'b0;
            result_pend <= 1'b0;
            ready_q     <= 1'b0;
            start       <= 1'b0;
            ctrl        <= '0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
            end else if (ready_q) begin
                busy <= 1'b0;
            end
            // Result reads wait one more cycle for the RAM
            result_pend <= accept && hit_result;
            ready_q     <= (accept && !hit_result) || result_pend;
            start       <= accept && hit_start && write;
            if (accept && hit_status && write) begin
                ctrl <= iomem_req.wdata[FRAME_W:0];
            end
        end
    end

    always_ff @(posedge ck) begin
        if (result_pend) begin
            rdata_q <= {{(32 - SAMPLE_W){result_rdata[SAMPLE_W-1]}}, result_rdata};
        end else if (accept && hit_status) begin
            rdata_q <= {{(29 - FRAME_W){1'b0}}, frame, error, done, allow};
        end else begin
            rdata_q <= '0;
        end
    end

    assign iomem_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

/* src/op_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program word decoder
// Forms the audio read address in the fetch cycle
// Stop stays high from reset or a halt/bad word until start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module op_decode (
    input  logic                                ck,
    input  logic                                rst,
    input  logic                                start,
    input  logic                                fetch_valid,
    input  audio_dsp_pkg::prog_word_u           word,
    input  logic [audio_dsp_pkg::FRAME_W-1:0]   frame,
    output logic [audio_dsp_pkg::AUDIO_W-1:0]   audio_raddr,
    output audio_dsp_pkg::exec_cmd_t            cmd,
    output logic                                stop
);
    import audio_dsp_pkg::*;

    logic [FRAME_W-1:0] tap;
    exec_cmd_t          next;

    // Frame index wraps around the channel's history
    assign tap         = frame - word.mac.delay;
    assign audio_raddr = {word.mac.chan, tap};

    always_comb begin
        next.valid = fetch_valid && !stop && !start;
        next.kind  = word.mac.op;
        next.coef  = (word.mac.op == OP_MAC) ? word.mac.coef : '0;
        next.slot  = (word.save.op == OP_SAVE) ? word.save.slot : '0;
    end

    always_ff @(posedge ck) begin
        if (rst) begin
            stop      <= 1'b1;
            cmd.valid <= 1'b0;
        end else begin
            cmd <= next;
            if (start) begin
                stop <= 1'b0;
            end else if (next.valid && (next.kind == OP_HALT || next.kind == OP_BAD)) begin
                stop <= 1'b1;
            end
        end
    end

endmodule

/* src/mac_execute.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multiply-accumulate stage
// Sample and command arrive in the same cycle
// A save passes the accumulator on and clears it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module mac_execute (
    input  logic                                      ck,
    input  logic                                      rst,
    input  logic                                      start,
    input  audio_dsp_pkg::exec_cmd_t                  cmd,
    input  logic signed [audio_dsp_pkg::SAMPLE_W-1:0] sample,
    output audio_dsp_pkg::result_cmd_t                res
);
    import audio_dsp_pkg::*;

    acc_t               acc;
    logic signed [31:0] product;

    assign product = sample * cmd.coef;

    always_ff @(posedge ck) begin
        if (rst || start) begin
            acc       <= '0;
            res.valid <= 1'b0;
        end else begin
            if (cmd.valid && cmd.kind == OP_MAC) begin
                acc <= acc + product;
            end else if (cmd.valid && cmd.kind == OP_SAVE) begin
                acc <= '0;
            end
            res.valid <= cmd.valid;
            res.kind  <= cmd.kind;
            res.slot  <= cmd.slot;
            res.acc   <= acc;
        end
    end

endmodule

/* src/result_writer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stage
// Scales the accumulator back to Q15 and clamps to 16 bits
// Done and error hold until the next start
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module result_writer (
    input  logic                                ck,
    input  logic                                rst,
    input  logic                                start,
    input  audio_dsp_pkg::result_cmd_t          res,
    output logic                                out_we,
    output logic [audio_dsp_pkg::SLOT_W-1:0]    out_addr,
    output logic [audio_dsp_pkg::SAMPLE_W-1:0]  out_data,
    output logic                                done,
    output logic                                error
);
    import audio_dsp_pkg::*;

    acc_t scaled;

    assign scaled = res.acc >>> Q_FRAC;

    always_comb begin
        if (scaled > 32767) begin
            out_data = 16'h7fff;
        end else if (scaled < -32768) begin
            out_data = 16'h8000;
        end else begin
            out_data = scaled[SAMPLE_W-1:0];
        end
    end

    assign out_we   = res.valid && res.kind == OP_SAVE;
    assign out_addr = res.slot;

    always_ff @(posedge ck) begin
        if (rst || start) begin
            done  <= 1'b0;
            error <= 1'b0;
        end else if (res.valid) begin
            // bad word ends the run with both flags
            if (res.kind == OP_HALT || res.kind == OP_BAD) begin
                done <= 1'b1;
            end
            if (res.kind == OP_BAD) begin
                error <= 1'b1;
            end
        end
    end

endmodule

/* src/sequencer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch and pipeline of the audio engine
// Fetches one word per cycle from start until stop
// Running off the end of program RAM ends as a bad word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module sequencer (
    input  logic                                ck,
    input  logic                                rst,
    input  logic                                start,
    input  logic [audio_dsp_pkg::FRAME_W-1:0]   frame,
    output logic [audio_dsp_pkg::CODE_W-1:0]    coef_raddr,
    input  logic [31:0]                         coef_rdata,
    output logic [audio_dsp_pkg::AUDIO_W-1:0]   audio_raddr,
    input  logic [audio_dsp_pkg::SAMPLE_W-1:0]  audio_rdata,
    output logic                                out_we,
    output logic [audio_dsp_pkg::SLOT_W-1:0]    out_addr,
    output logic [audio_dsp_pkg::SAMPLE_W-1:0]  out_data,
    output logic                                done,
    output logic                                error
);
    import audio_dsp_pkg::*;

    // Extra top bit marks a wrap past the last word
    logic [CODE_W:0] pc;
    logic            fetch_valid, fetch_over, stop;
    prog_word_u      word;
    exec_cmd_t       cmd;
    result_cmd_t     res;

    assign coef_raddr = pc[CODE_W-1:0];
    assign word       = fetch_over ? {OP_BAD, 30'd0} : coef_rdata;

    always_ff @(posedge ck) begin
        if (rst) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
            fetch_over  <= 1'b0;
        end else begin
            if (start) begin
                pc <= '0;
            end else if (!stop) begin
                pc <= pc + 1'b1;
            end
            // Valid bit travels alongside the RAM read
            fetch_valid <= !stop && !start;
            fetch_over  <= pc[CODE_W];
        end
    end

    op_decode u_decode (
        .ck(ck), .rst(rst), .start(start), .fetch_valid(fetch_valid),
        .word(word), .frame(frame), .audio_raddr(audio_raddr),
        .cmd(cmd), .stop(stop)
    );

    mac_execute u_execute (
        .ck(ck), .rst(rst), .start(start), .cmd(cmd),
        .sample(audio_rdata), .res(res)
    );

    result_writer u_result (
        .ck(ck), .rst(rst), .start(start), .res(res),
        .out_we(out_we), .out_addr(out_addr), .out_data(out_data),
        .done(done), .error(error)
    );

endmodule

/* src/audio_engine.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Audio filter peripheral, top level
// Program, sample history and results live in three RAMs
// RAM contents are not cleared by reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module audio_engine (
    input  logic                      ck,
    input  logic                      rst,
    input  audio_bus_pkg::iomem_req_t iomem_req,
    output audio_bus_pkg::iomem_rsp_t iomem_rsp
);
    import audio_dsp_pkg::*;

    logic                coef_we, audio_we, out_we, start, done, error;
    logic [CODE_W-1:0]   coef_raddr;
    logic [31:0]         coef_rdata;
    logic [AUDIO_W-1:0]  audio_raddr;
    logic [SAMPLE_W-1:0] audio_rdata, out_data, result_rdata;
    logic [SLOT_W-1:0]   out_addr, result_raddr;
    logic [FRAME_W-1:0]  frame;

    dpram #(.BITS(32), .SIZE(CODE)) coef_ram (
        .ck(ck), .we(coef_we), .waddr(iomem_req.addr[CODE_W+1:2]),
        .wdata(iomem_req.wdata), .re(1'b1), .raddr(coef_raddr), .rdata(coef_rdata)
    );

    dpram #(.BITS(SAMPLE_W), .SIZE(AUDIO)) audio_ram (
        .ck(ck), .we(audio_we), .waddr(iomem_req.addr[AUDIO_W+1:2]),
        .wdata(iomem_req.wdata[SAMPLE_W-1:0]), .re(1'b1),
        .raddr(audio_raddr), .rdata(audio_rdata)
    );

    dpram #(.BITS(SAMPLE_W), .SIZE(SLOTS)) result_ram (
        .ck(ck), .we(out_we), .waddr(out_addr), .wdata(out_data),
        .re(1'b1), .raddr(result_raddr), .rdata(result_rdata)
    );

    bus_port u_bus (
        .ck(ck), .rst(rst), .iomem_req(iomem_req), .iomem_rsp(iomem_rsp),
        .coef_we(coef_we), .audio_we(audio_we), .result_raddr(result_raddr),
        .result_rdata(result_rdata), .done(done), .error(error),
        .frame(frame), .start(start)
    );

    sequencer u_seq (
        .ck(ck), .rst(rst), .start(start), .frame(frame),
        .coef_raddr(coef_raddr), .coef_rdata(coef_rdata),
        .audio_raddr(audio_raddr), .audio_rdata(audio_rdata),
        .out_we(out_we), .out_addr(out_addr), .out_data(out_data),
        .done(done), .error(error)
    );

endmodule

/* test/tb_clock.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// 100 ns period, reset high for the first 5 rising edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module tb_clock (
    output logic ck,
    output logic rst
);

    initial begin
        ck = 1'b0;
        forever #50 ck = ~ck;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge ck);
        rst <= 1'b0;
    end

endmodule

/* test/audio_engine_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the audio filter peripheral
// Result RAM is not reset, so a first run saves 0 to all slots
// Bus waits give up after 20 cycles, the done poll after 2000
// Random stimulus comes from $urandom with seed 88
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module audio_engine_tb;
    import audio_bus_pkg::*;
    import audio_dsp_pkg::*;

    logic       ck, rst;
    iomem_req_t req;
    iomem_rsp_t rsp;

    // Shadow state of what the host has written
    logic [31:0] shadow_prog [CODE];
    logic [15:0] shadow_audio [AUDIO];
    logic        shadow_allow;
    logic [4:0]  shadow_frame;
    int          exp_slot [SLOTS];
    logic        exp_error;

    int    got_q [$];
    int    exp_q [$];
    string tag_q [$];
    int    cmp_got, cmp_exp;
    string cmp_tag;
    int    checks = 0;
    int    mismatches = 0;
    int    timeouts = 0;
    int    cycles = 0;
    int    chans [4];

    tb_clock clock_i (.ck(ck), .rst(rst));

    audio_engine dut_i (.ck(ck), .rst(rst), .iomem_req(req), .iomem_rsp(rsp));

    always @(posedge ck) cycles <= cycles + 1;

    // Compare process, drains the queued observations
    always @(posedge ck) begin
        while (got_q.size() > 0) begin
            cmp_got = got_q.pop_front();
            cmp_exp = exp_q.pop_front();
            cmp_tag = tag_q.pop_front();
            checks++;
            if (cmp_got != cmp_exp) begin
                mismatches++;
                $display("Fail at %0t ns: %s got %0d expected %0d",
                         $time, cmp_tag, cmp_got, cmp_exp);
            end
        end
    end

    task automatic finish_run();
        $display("Checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic expect_val(input int got, input int exp, input string tag);
        got_q.push_back(got);
        exp_q.push_back(exp);
        tag_q.push_back(tag);
    endtask

    function automatic logic [31:0] region_addr(input logic [15:0] region, input int offset);
        return {AE_BASE + region, 16'h0000} + offset;
    endfunction

    function automatic logic [31:0] mac_word(input int ch, input int dly, input int coef);
        return {OP_MAC, ch[3:0], dly[4:0], 5'd0, coef[15:0]};
    endfunction

    function automatic logic [31:0] save_word(input int slot);
        return {OP_SAVE, slot[3:0], 26'd0};
    endfunction

    // Reference model of one run over the shadow program
    function automatic void model_run(input logic [4:0] frm);
        longint      acc;
        longint      scaled;
        int          pc;
        logic [31:0] w;
        logic [4:0]  tap;
        logic        running;
        acc = 0;
        pc = 0;
        running = 1'b1;
        exp_error = 1'b0;
        while (running) begin
            if (pc >= CODE) begin
                exp_error = 1'b1;
                running = 1'b0;
            end else begin
                w = shadow_prog[pc];
                case (w[31:30])
                    2'd0: begin
                        tap = frm - w[25:21];
                        acc = acc + longint'($signed(shadow_audio[{w[29:26], tap}]))
                                    * longint'($signed(w[15:0]));
                    end
                    2'd1: begin
                        scaled = acc >>> 15;
                        if (scaled > 32767) begin
                            scaled = 32767;
                        end else if (scaled < -32768) begin
                            scaled = -32768;
                        end
                        exp_slot[w[29:26]] = int'(scaled);
                        acc = 0;
                    end
                    2'd2: begin
                        running = 1'b0;
                    end
                    default: begin
                        exp_error = 1'b1;
                        running = 1'b0;
                    end
                endcase
                pc++;
            end
        end
    endfunction

    task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic wr, output logic [31:0] rdata);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        rdata = '0;
        @(posedge ck);
        req <= '{valid: 1'b1, wstrb: (wr ? 4'hf : 4'h0), addr: addr, wdata: data};
        while (!seen && n < 20) begin
            @(posedge ck);
            n++;
            if (rsp.ready) begin
                seen = 1'b1;
                rdata = rsp.rdata;
            end
        end
        req <= '0;
        if (!seen) begin
            timeouts++;
            $display("No ready from the DUT within 20 cycles for address %08h", addr);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(addr, data, 1'b1, unused);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        bus_access(addr, 32'd0, 1'b0, data);
    endtask

    task automatic set_control(input logic allow, input logic [4:0] frm);
        bus_write(region_addr(REGION_STATUS, 0), {26'd0, frm, allow});
        shadow_allow = allow;
        shadow_frame = frm;
    endtask

    task automatic load_word(input int k, input logic [31:0] w);
        bus_write(region_addr(REGION_COEF, 4 * k), w);
        shadow_prog[k] = w;
    endtask

    task automatic audio_write(input int idx, input int val);
        bus_write(region_addr(REGION_INPUT, 4 * idx), {16'd0, val[15:0]});
        // Gated writes are acknowledged but leave the history alone
        if (shadow_allow) begin
            shadow_audio[idx] = val[15:0];
        end
    endtask

    task automatic wait_done(output logic [31:0] st);
        int t0;
        t0 = cycles;
        st = '0;
        while (!st[1] && cycles - t0 < 2000) begin
            bus_read(region_addr(REGION_STATUS, 0), st);
        end
        if (!st[1]) begin
            timeouts++;
            $display("Engine did not report done within 2000 cycles");
        end
    endtask

    task automatic run_and_check(input string name);
        logic [31:0] st;
        logic [31:0] v;
        int          s;
        model_run(shadow_frame);
        bus_write(region_addr(REGION_START, 0), 32'd1);
        wait_done(st);
        expect_val(int'(st[2]), int'(exp_error), {name, " error"});
        for (s = 0; s < SLOTS; s++) begin
            bus_read(region_addr(REGION_RESULT, 4 * s), v);
            expect_val($signed(v), exp_slot[s], $sformatf("%s slot %0d", name, s));
        end
    endtask

    task automatic status_readback();
        logic [31:0] st;
        logic [4:0]  f;
        f = 5'($urandom_range(0, 31));
        set_control(1'b1, f);
        bus_read(region_addr(REGION_STATUS, 0), st);
        expect_val(int'(st), int'({24'd0, f, 3'b001}), "status readback");
    endtask

    task automatic clear_results();
        int s;
        for (s = 0; s < SLOTS; s++) begin
            load_word(s, save_word(s));
        end
        load_word(SLOTS, {OP_HALT, 30'd0});
        run_and_check("clear");
    endtask

    // Random 16 MAC and 8 save program over four loaded channels
    task automatic filter_run();
        int c, fr, g, m, k;
        set_control(1'b1, 5'($urandom_range(0, 31)));
        for (c = 0; c < 4; c++) begin
            chans[c] = 4 * c + int'($urandom_range(0, 3));
            for (fr = 0; fr < FRAMES; fr++) begin
                audio_write(chans[c] * FRAMES + fr, int'($urandom_range(0, 65535)));
            end
        end
        k = 0;
        for (g = 0; g < 8; g++) begin
            for (m = 0; m < 2; m++) begin
                load_word(k, mac_word(chans[$urandom_range(0, 3)],
                                      int'($urandom_range(0, 31)),
                                      int'($urandom_range(0, 65535))));
                k++;
            end
            load_word(k, save_word(int'($urandom_range(0, 15))));
            k++;
        end
        load_word(k, {OP_HALT, 30'd0});
        run_and_check("filter");
    endtask

    // Every sample of the loaded channels is offered a different value
    task automatic write_gate();
        int c, fr, idx;
        set_control(1'b0, shadow_frame);
        for (c = 0; c < 4; c++) begin
            for (fr = 0; fr < FRAMES; fr++) begin
                idx = chans[c] * FRAMES + fr;
                audio_write(idx, int'(~shadow_audio[idx]));
            end
        end
        run_and_check("write gate");
    endtask

    task automatic frame_delay();
        set_control(1'b1, shadow_frame + 5'd7);
        run_and_check("frame delay");
    endtask

    task automatic saturation();
        set_control(1'b1, 5'd0);
        audio_write(8 * FRAMES, 32'h7fff);
        audio_write(8 * FRAMES + 31, 32'h8000);
        load_word(0, mac_word(8, 0, 32'h7fff));
        load_word(1, mac_word(8, 0, 32'h7fff));
        load_word(2, save_word(0));
        load_word(3, mac_word(8, 1, 32'h7fff));
        load_word(4, mac_word(8, 1, 32'h7fff));
        load_word(5, save_word(1));
        load_word(6, mac_word(8, 1, 32'h8000));
        load_word(7, save_word(2));
        load_word(8, {OP_HALT, 30'd0});
        run_and_check("saturation");
    endtask

    // Third word is bad, the save behind it must not run
    task automatic bad_opcode();
        load_word(0, mac_word(chans[0], 3, int'($urandom_range(0, 65535))));
        load_word(1, save_word(5));
        load_word(2, {OP_BAD, 30'd0});
        load_word(3, save_word(6));
        load_word(4, {OP_HALT, 30'd0});
        run_and_check("bad opcode");
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(posedge ck);
            n++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("Reset was never released");
        end
    endtask

    task automatic drain_checks();
        int n;
        n = 0;
        while (got_q.size() != 0 && n < 20) begin
            @(posedge ck);
            n++;
        end
        if (got_q.size() != 0) begin
            timeouts++;
            $display("Compare process left %0d checks unprocessed", got_q.size());
        end
    endtask

    initial begin
        req <= '0;
        shadow_allow = 1'b0;
        shadow_frame = 5'd0;
        foreach (exp_slot[i]) begin
            exp_slot[i] = 0;
        end
        void'($urandom(88));
        // The sequence ends early as soon as any wait has timed out
        fork
            begin
                wait_reset();
                status_readback();
                clear_results();
                filter_run();
                write_gate();
                frame_delay();
                saturation();
                bad_opcode();
                drain_checks();
            end
            wait (timeouts != 0);
        join_any
        finish_run();
    end

endmodule

/* audio_engine.f */
src/audio_bus_pkg.sv
src/audio_dsp_pkg.sv
src/dpram.sv
src/bus_port.sv
src/op_decode.sv
src/mac_execute.sv
src/result_writer.sv
src/sequencer.sv
src/audio_engine.sv
test/tb_clock.sv
test/audio_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the audio engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
    --top-module audio_engine_tb -f audio_engine.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vaudio_engine_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
